// ==== files.f ====
verilog/cache_pkg.sv
verilog/way_bank.sv
verilog/plru_ctrl.sv
verilog/l2_set_store.sv
verification/l2_set_store_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds and runs the set store testbench with Verilator
# exit status is non-zero when the run fails
set -e

cd "$(dirname "$0")"

rm -rf obj_dir

verilator --binary --timing --assert -j 0 \
    --top-module l2_set_store_tb \
    -f files.f \
    -o l2_set_store_sim

./obj_dir/l2_set_store_sim

echo "simulation finished"

// ==== verification/l2_set_store_tb.sv ====
// set store testbench; run from the project root, default SET_BITS only, stops at the first error
`timescale 1ns/1ps

module l2_set_store_tb
    import cache_pkg::*;
();

    localparam int SET_BITS     = DEF_SET_BITS;
    localparam int NUM_SETS     = 2 ** SET_BITS;
    localparam int CLK_PERIOD   = 100;
    localparam int DRIVE_DELAY  = 10;
    localparam int RESET_CYCLES = 5;
    localparam int IDLE_CYCLES  = 6;
    localparam string STIM_FILE = "verification/l2_stim.txt";

    logic                clk;
    logic                arst_n;
    logic [SET_BITS-1:0] index;
    fill_req_t           fill;
    tag_set_t            tags;
    line_set_t           lines;
    plru_t               plru;
    logic                complete;

    // vectors from the stim file, one entry per row
    logic [7:0]          vec_op [$];
    logic [SET_BITS-1:0] vec_index [$];
    way_t                vec_way [$];
    tag_entry_t          vec_tag [$];
    logic [31:0]         vec_seed [$];
    plru_t               vec_plru [$];
    logic                stim_loaded = 1'b0;

    // reference model of the arrays
    tag_entry_t model_tag [NUM_SETS][NUM_WAYS];
    line_t      model_line [NUM_SETS][NUM_WAYS];
    plru_t      model_plru [NUM_SETS];
    // completion predicted for the current cycle
    logic       expect_complete;

    l2_set_store #(
        .SET_BITS (SET_BITS)
    ) u_l2_set_store (
        .clk      (clk),
        .arst_n   (arst_n),
        .index    (index),
        .fill     (fill),
        .tags     (tags),
        .lines    (lines),
        .plru     (plru),
        .complete (complete)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2);
            clk = ~clk;
        end
    end

    // prints the reason, then the fail message, then ends the run
    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("*** TEST FAILED ***");
        $fatal(1, "run aborted");
    endtask

    task automatic check_value(input string name, input logic [LINE_W-1:0] actual,
                               input logic [LINE_W-1:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("[FAIL] t=%0t %s actual=%0h expected=%0h",
                                $time, name, actual, expected));
        end
    endtask

    // tree update, written straight from the bit rules
    function automatic plru_t plru_after_fill(input plru_t cur, input way_t w);
        plru_t p;
        p = cur;
        case (w)
            2'd0: begin
                p[1] = 1'b1;
                p[0] = 1'b1;
            end
            2'd1: begin
                p[1] = 1'b0;
                p[0] = 1'b1;
            end
            2'd2: begin
                p[2] = 1'b1;
                p[0] = 1'b0;
            end
            default: begin
                p[2] = 1'b0;
                p[0] = 1'b0;
            end
        endcase
        return p;
    endfunction

    function automatic tag_entry_t tag_lane(input tag_set_t s, input int w);
        case (w)
            0:       return s.way0;
            1:       return s.way1;
            2:       return s.way2;
            default: return s.way3;
        endcase
    endfunction

    function automatic line_t line_lane(input line_set_t s, input int w);
        case (w)
            0:       return s.way0;
            1:       return s.way1;
            2:       return s.way2;
            default: return s.way3;
        endcase
    endfunction

    // arrays start empty, same as the DUT
    function automatic void clear_model();
        for (int s = 0; s < NUM_SETS; s++) begin
            model_plru[s] = '0;
            for (int w = 0; w < NUM_WAYS; w++) begin
                model_tag[s][w]  = '0;
                model_line[s][w] = '0;
            end
        end
    endfunction

    task automatic load_stim();
        int          fd;
        int          fields;
        int          line_no;
        string       text;
        logic [7:0]  op;
        logic [31:0] idx;
        logic [31:0] way;
        logic [31:0] tag;
        logic [31:0] seed;
        logic [31:0] exp_plru;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            abort_run($sformatf("cannot open stimulus file %s", STIM_FILE));
        end else begin
            line_no = 0;
            while ($fgets(text, fd) != 0) begin
                line_no++;
                // skip comments and blank lines
                if (text.len() > 1 && text[0] != "#") begin
                    fields = $sscanf(text, "%c %h %h %h %h %h",
                                     op, idx, way, tag, seed, exp_plru);
                    if (fields != 6 || (op != "F" && op != "R") || idx >= NUM_SETS
                            || way >= NUM_WAYS) begin
                        abort_run($sformatf("cannot parse line %0d of %s", line_no, STIM_FILE));
                    end else begin
                        vec_op.push_back(op);
                        vec_index.push_back(SET_BITS'(idx));
                        vec_way.push_back(2'(way));
                        vec_tag.push_back(TAG_W'(tag));
                        vec_seed.push_back(seed);
                        vec_plru.push_back(3'(exp_plru));
                    end
                end
            end
            $fclose(fd);
            if (vec_op.size() == 0) begin
                abort_run($sformatf("no vectors found in %s", STIM_FILE));
            end
        end
    endtask

    // compare all read outputs against the model, with the fill forwarded on its lane
    task automatic check_outputs(input logic [SET_BITS-1:0] idx, input logic is_fill,
                                 input way_t way, input tag_entry_t new_tag,
                                 input line_t new_line, input plru_t exp_plru);
        tag_entry_t exp_tag;
        line_t      exp_line;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (is_fill && int'(way) == w) begin
                exp_tag  = new_tag;
                exp_line = new_line;
            end else begin
                exp_tag  = model_tag[idx][w];
                exp_line = model_line[idx][w];
            end
            check_value($sformatf("tags.way%0d set %0h", w, idx),
                        LINE_W'(tag_lane(tags, w)), LINE_W'(exp_tag));
            check_value($sformatf("lines.way%0d set %0h", w, idx),
                        line_lane(lines, w), exp_line);
        end
        check_value($sformatf("plru set %0h", idx), LINE_W'(plru), LINE_W'(exp_plru));
        check_value("complete", LINE_W'(complete), LINE_W'(expect_complete));
    endtask

    // one stim row takes one clock cycle
    task automatic run_vector(input int i);
        logic                is_fill;
        logic [SET_BITS-1:0] idx;
        way_t                way;
        line_t               line_val;
        plru_t               exp_plru;
        is_fill  = (vec_op[i] == "F");
        idx      = vec_index[i];
        way      = vec_way[i];
        // line is the 32-bit seed repeated across the whole line
        line_val = {(LINE_W / 32){vec_seed[i]}};
        exp_plru = is_fill ? plru_after_fill(model_plru[idx], way) : model_plru[idx];
        @(posedge clk);
        #DRIVE_DELAY;
        index     = idx;
        fill.we   = is_fill;
        fill.way  = way;
        fill.tag  = vec_tag[i];
        fill.line = line_val;
        #(CLK_PERIOD - 2 * DRIVE_DELAY);
        check_outputs(idx, is_fill, way, vec_tag[i], line_val, exp_plru);
        check_value($sformatf("plru vs stim row %0d", i), LINE_W'(plru), LINE_W'(vec_plru[i]));
        // the coming edge writes the fill
        if (is_fill) begin
            model_tag[idx][way]  = vec_tag[i];
            model_line[idx][way] = line_val;
            model_plru[idx]      = exp_plru;
        end
        expect_complete = is_fill;
    endtask

    // no fill, random set read back
    task automatic idle_cycle();
        logic [SET_BITS-1:0] idx;
        idx = SET_BITS'($urandom_range(NUM_SETS - 1, 0));
        @(posedge clk);
        #DRIVE_DELAY;
        index = idx;
        fill  = '0;
        #(CLK_PERIOD - 2 * DRIVE_DELAY);
        check_outputs(idx, 1'b0, 2'd0, '0, '0, model_plru[idx]);
        expect_complete = 1'b0;
    endtask

    // watchdog, sized from the vector count
    initial begin
        wait (stim_loaded);
        #((vec_op.size() + 20) * CLK_PERIOD);
        abort_run($sformatf("timeout: run did not finish within %0d cycles",
                            vec_op.size() + 20));
    end

    initial begin
        void'($urandom(92));
        arst_n          = 1'b0;
        index           = '0;
        fill            = '0;
        expect_complete = 1'b0;
        clear_model();
        load_stim();
        stim_loaded = 1'b1;
        $display("%0d vectors loaded", vec_op.size());
        // reset held, index wanders
        repeat (RESET_CYCLES) begin
            @(posedge clk);
            #DRIVE_DELAY;
            index = SET_BITS'($urandom_range(NUM_SETS - 1, 0));
        end
        arst_n = 1'b1;
        for (int i = 0; i < vec_op.size(); i++) begin
            run_vector(i);
        end
        repeat (IDLE_CYCLES) begin
            idle_cycle();
        end
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// ==== verification/l2_stim.txt ====
# op index way tag line_seed plru_after, all hex, op F = fill or R = read
# line is line_seed repeated 16 times; way, tag and seed are ignored on reads
# reset state
R 000 0 00000 00000000 0
R 001 0 00000 00000000 0
R 0a5 0 00000 00000000 0
R 100 0 00000 00000000 0
R 1ff 0 00000 00000000 0
# ways 0, 2, 1, 3 back to back at one set
F 012 0 1a001 11111111 3
F 012 2 2b002 22222222 6
F 012 1 3c003 33333333 5
F 012 3 4d004 44444444 0
R 012 0 00000 00000000 0
R 013 0 00000 00000000 0
R 011 0 00000 00000000 0
R 012 0 00000 00000000 0
# lowest and highest set, spaced fills
F 000 1 00abc deadbeef 1
R 000 0 00000 00000000 1
R 1ff 0 00000 00000000 0
F 1ff 2 7ffff cafef00d 4
R 1ff 0 00000 00000000 4
R 000 0 00000 00000000 1
F 1ff 0 12345 0badc0de 7
R 1ff 0 00000 00000000 7
F 000 3 55555 a5a5a5a5 0
R 000 0 00000 00000000 0
R 1ff 0 00000 00000000 7
R 012 0 00000 00000000 0
# overwrite of one way
F 012 2 66666 5a5a5a5a 4
R 012 0 00000 00000000 4
# interleaved fills at neighbouring sets
F 0a5 0 0a5a5 01234567 3
F 0a6 1 0a6a6 89abcdef 1
F 0a5 3 0a5a6 fedcba98 2
R 0a5 0 00000 00000000 2
R 0a6 0 00000 00000000 1
R 012 0 00000 00000000 4
F 0a5 1 11111 76543210 1
R 0a5 0 00000 00000000 1
# all four ways at one set
F 100 3 70003 30303030 0
F 100 1 70001 10101010 1
F 100 2 70002 20202020 4
F 100 0 70000 00000001 7
R 100 0 00000 00000000 7
R 0ff 0 00000 00000000 0
R 101 0 00000 00000000 0
R 000 0 00000 00000000 0
R 1ff 0 00000 00000000 7
R 0a6 0 00000 00000000 1
# second round on the edge sets
F 1ff 1 7fffe ffffffff 5
R 1ff 0 00000 00000000 5
R 000 0 00000 00000000 0
F 000 0 00001 80000001 3
R 000 0 00000 00000000 3
R 1ff 0 00000 00000000 5
R 012 0 00000 00000000 4
R 100 0 00000 00000000 7
R 0a5 0 00000 00000000 1

// ==== verilog/cache_pkg.sv ====
// shared cache types; tag and line widths are fixed here and only the index width is a parameter
package cache_pkg;

    // associativity, the tree pseudo-LRU below assumes exactly four ways
    localparam int NUM_WAYS = 4;

    // default index width, 512 sets
    localparam int DEF_SET_BITS = 9;

    // stored tag plus two flag bits
    localparam int TAG_W = 19;

    // one cache line, 64 bytes
    localparam int LINE_W = 512;

    // way number of a fill
    typedef logic [1:0] way_t;

    // one-hot lane write enable, all zero when idle
    typedef logic [NUM_WAYS-1:0] way_en_t;

    // tree state per set
    // bit 2 picks within ways 2/3, bit 1 within ways 0/1, bit 0 picks the pair
    typedef logic [2:0] plru_t;

    typedef logic [TAG_W-1:0]  tag_entry_t;
    typedef logic [LINE_W-1:0] line_t;

    // one fill from the next level, always accepted
    typedef struct packed {
        logic       we;
        way_t       way;
        tag_entry_t tag;
        line_t      line;
    } fill_req_t;

    // all four tag lanes of one set
    typedef struct packed {
        tag_entry_t way0;
        tag_entry_t way1;
        tag_entry_t way2;
        tag_entry_t way3;
    } tag_set_t;

    // all four line lanes of one set
    typedef struct packed {
        line_t way0;
        line_t way1;
        line_t way2;
        line_t way3;
    } line_set_t;

endpackage

// ==== verilog/l2_set_store.sv ====
// L2 4-way set store; reads are combinational, fills always accepted, only complete is reset
`timescale 1ns/1ps

module l2_set_store
    import cache_pkg::*;
#(
    parameter int SET_BITS = DEF_SET_BITS
) (
    input  logic                clk,
    input  logic                arst_n,
    // set address for reads and fills
    input  logic [SET_BITS-1:0] index,
    input  fill_req_t           fill,
    // all four ways of the indexed set
    output tag_set_t            tags,
    output line_set_t           lines,
    output plru_t               plru,
    output logic                complete
);

    // lane enable shared by both banks
    way_en_t way_en;

    // raw bank outputs, lane 0 is way 0
    logic [NUM_WAYS-1:0][TAG_W-1:0]  tag_rd;
    logic [NUM_WAYS-1:0][LINE_W-1:0] line_rd;

    // fill decode, tree state and completion
    plru_ctrl #(
        .SET_BITS (SET_BITS)
    ) u_ctrl (
        .clk      (clk),
        .arst_n   (arst_n),
        .index    (index),
        .fill_we  (fill.we),
        .fill_way (fill.way),
        .way_en   (way_en),
        .plru     (plru),
        .complete (complete)
    );

    // tag entries with their flag bits
    way_bank #(
        .SET_BITS (SET_BITS),
        .ENTRY_W  (TAG_W)
    ) u_tag_bank (
        .clk    (clk),
        .index  (index),
        .way_en (way_en),
        .wdata  (fill.tag),
        .rdata  (tag_rd)
    );

    // line data
    way_bank #(
        .SET_BITS (SET_BITS),
        .ENTRY_W  (LINE_W)
    ) u_line_bank (
        .clk    (clk),
        .index  (index),
        .way_en (way_en),
        .wdata  (fill.line),
        .rdata  (line_rd)
    );

    // struct field way0 is the top slice, so pack by name and not by concatenation
    assign tags.way0  = tag_rd[0];
    assign tags.way1  = tag_rd[1];
    assign tags.way2  = tag_rd[2];
    assign tags.way3  = tag_rd[3];

    assign lines.way0 = line_rd[0];
    assign lines.way1 = line_rd[1];
    assign lines.way2 = line_rd[2];
    assign lines.way3 = line_rd[3];

endmodule

// ==== verilog/plru_ctrl.sv ====
// fill decode and per-set tree PLRU; the PLRU array is not cleared by arst_n, only complete is
`timescale 1ns/1ps

module plru_ctrl
    import cache_pkg::*;
#(
    parameter int SET_BITS = DEF_SET_BITS
) (
    input  logic                clk,
    input  logic                arst_n,
    input  logic [SET_BITS-1:0] index,
    // fill strobe and target way, no back-pressure
    input  logic                fill_we,
    input  way_t                fill_way,
    // lane write enable for both banks
    output way_en_t             way_en,
    // tree state of the indexed set, updated value during a fill
    output plru_t               plru,
    // one cycle after each fill edge
    output logic                complete
);

    localparam int NUM_SETS = 2 ** SET_BITS;

    // per-set tree bits
    plru_t plru_mem [NUM_SETS];

    // stored value at index
    plru_t plru_cur;
    // value after a fill of fill_way
    plru_t plru_next;

    initial begin
        for (int s = 0; s < NUM_SETS; s++) begin
            plru_mem[s] = '0;
        end
    end

    // one-hot decode of the fill way
    always_comb begin
        way_en = '0;
        if (fill_we) begin
            way_en[fill_way] = 1'b1;
        end
    end

    assign plru_cur = plru_mem[index];

    // tree update
    // the filled way's leaf bit and the pair bit both point away from it,
    // the other subtree keeps its bit
    always_comb begin
        case (fill_way)
            2'd0:    plru_next = {plru_cur[2], 1'b1, 1'b1};
            2'd1:    plru_next = {plru_cur[2], 1'b0, 1'b1};
            2'd2:    plru_next = {1'b1, plru_cur[1], 1'b0};
            default: plru_next = {1'b0, plru_cur[1], 1'b0};
        endcase
    end

    // forward the new tree state in the fill cycle
    assign plru = fill_we ? plru_next : plru_cur;

    always_ff @(posedge clk) begin
        if (fill_we) begin
            plru_mem[index] <= plru_next;
        end
    end

    // completion pulse, stays high across back-to-back fills
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            complete <= 1'b0;
        end else begin
            complete <= fill_we;
        end
    end

    // an unknown way would write an unknown lane in both banks
    a_fill_way_known : assert property (
        @(posedge clk) disable iff (!arst_n)
        fill_we |-> !$isunknown(fill_way)
    ) else $error("plru_ctrl: fill with unknown way %b", fill_way);

endmodule

// ==== verilog/way_bank.sv ====
// four-lane set memory; contents start at zero from initial load and are never reset
`timescale 1ns/1ps

module way_bank
    import cache_pkg::*;
#(
    parameter int SET_BITS = DEF_SET_BITS,
    parameter int ENTRY_W  = TAG_W
) (
    input  logic                              clk,
    // set address, shared by read and write
    input  logic [SET_BITS-1:0]               index,
    // one-hot lane select, zero means no write
    input  way_en_t                           way_en,
    input  logic [ENTRY_W-1:0]                wdata,
    // lane w of the indexed row
    output logic [NUM_WAYS-1:0][ENTRY_W-1:0]  rdata
);

    localparam int NUM_SETS = 2 ** SET_BITS;

    // one row per set, four lanes side by side
    logic [NUM_WAYS-1:0][ENTRY_W-1:0] mem [NUM_SETS];

    // arrays come up empty
    initial begin
        for (int s = 0; s < NUM_SETS; s++) begin
            mem[s] = '0;
        end
    end

    // lane write
    // only the selected lane of the row changes, the others keep their value
    always_ff @(posedge clk) begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (way_en[w]) begin
                mem[index][w] <= wdata;
            end
        end
    end

    // combinational read at the current index
    // write data is forwarded on the enabled lane during the fill cycle
    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (way_en[w]) begin
                rdata[w] = wdata;
            end else begin
                rdata[w] = mem[index][w];
            end
        end
    end

    // enable comes from the controller decode
    // two lanes at once would corrupt the row and break forwarding
    a_way_en_onehot0 : assert property (
        @(posedge clk) $onehot0(way_en)
    ) else $error("way_bank: more than one lane enabled %b", way_en);

endmodule
